/* sources.f */
+incdir+.
floor_pkg.sv
car_io_pkg.sv
call_register.sv
floor_select.sv
car_command.sv
elevator_ctrl.sv
elevator_tb.sv

/* elevator_tb.sv */
// Testbench for the elevator request controller with a motion model and assertion checks

`timescale 1ns/10ps

`include "elevator_params.svh"

module elevator_tb;

    import car_io_pkg::*;
    import floor_pkg::*;

    logic         clock;
    logic         reset_n;
    button_bank_t buttons;
    car_status_t  status;
    logic         move_ack;
    lamp_bank_t   lamps;
    move_cmd_t    move_cmd;
    logic         move_req;
    logic         door_open_allowed;
    logic         door_close_allowed;

    lamp_bank_t   exp_lamps;
    move_cmd_t    exp_cmd;
    move_cmd_t    sel;
    direction_t   exp_dir;
    logic         exp_req;
    logic         wait_ack_low;
    logic         exp_door_open;
    logic         exp_door_close;
    int           mismatch_count;
    int           other_count;
    int           cycle_count;
    int           moves_done;

    elevator_ctrl elevator_ctrl_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .status             (status),
        .move_ack           (move_ack),
        .lamps              (lamps),
        .move_cmd           (move_cmd),
        .move_req           (move_req),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Lamp bank after one edge, following the press and clear rules
    function automatic lamp_bank_t next_lamps(lamp_bank_t l, button_bank_t b, car_status_t s);
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (b.power && !b.emergency && s.current_floor != i) begin
                l.call_lamps[i]  = l.call_lamps[i] | b.hall_calls[i];
                l.panel_lamps[i] = l.panel_lamps[i] | b.panel_buttons[i];
            end
            if (b.power && !s.moving && s.current_floor == i) begin
                l.call_lamps[i]  = 1'b0;
                l.panel_lamps[i] = 1'b0;
            end
        end
        return l;
    endfunction

    // Scans each side in toward the car so the last hit is the nearest request
    function automatic move_cmd_t pick_target(lamp_bank_t l, int cur, direction_t dir,
                                              output logic found);
        floor_mask_t p;
        int          up_f;
        int          dn_f;
        move_cmd_t   r;
        p = l.call_lamps | l.panel_lamps;
        up_f = -1;
        dn_f = -1;
        for (int f = `NUM_FLOORS - 1; f > cur; f--) begin
            if (p[f]) up_f = f;
        end
        for (int f = 0; f < cur; f++) begin
            if (p[f]) dn_f = f;
        end
        found = (up_f >= 0) || (dn_f >= 0);
        if (dir == DIR_UP && up_f >= 0) begin
            r = '{floor_t'(up_f), DIR_UP};
        end else if (dn_f >= 0) begin
            r = '{floor_t'(dn_f), DIR_DOWN};
        end else begin
            r = '{floor_t'(up_f < 0 ? 0 : up_f), DIR_UP};
        end
        return r;
    endfunction

    always @(posedge clock or negedge reset_n) begin
        logic found;
        if (!reset_n) begin
            exp_lamps      <= '0;
            exp_dir        <= DIR_UP;
            exp_req        <= 1'b0;
            wait_ack_low   <= 1'b0;
            exp_cmd        <= '0;
            exp_door_open  <= 1'b0;
            exp_door_close <= 1'b0;
        end else begin
            exp_lamps <= next_lamps(exp_lamps, buttons, status);
            // Door buttons only pass through with the car parked and powered
            if (!status.moving && buttons.power) begin
                exp_door_open  <= buttons.door_open;
                exp_door_close <= buttons.door_close;
            end else begin
                exp_door_open  <= 1'b0;
                exp_door_close <= 1'b0;
            end
            sel = pick_target(exp_lamps, status.current_floor, exp_dir, found);
            if (!exp_req && !wait_ack_low) begin
                if (found && !status.moving && buttons.power && !buttons.emergency
                        && !move_ack) begin
                    exp_req <= 1'b1;
                    exp_cmd <= sel;
                    exp_dir <= sel.dir;
                end
            end else if (exp_req) begin
                if (move_ack) begin
                    exp_req      <= 1'b0;
                    wait_ack_low <= 1'b1;
                end
            end else if (!move_ack) begin
                wait_ack_low <= 1'b0;
            end
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    a_lamps: assert property (@(posedge clock) disable iff (!reset_n) lamps == exp_lamps)
        else begin
            mismatch_count++;
            $display("mismatch lamps: got %h expected %h", $sampled(lamps), $sampled(exp_lamps));
        end

    a_stop_clear: assert property (@(posedge clock) disable iff (!reset_n)
        (buttons.power && !status.moving) |=>
            !(lamps.call_lamps[$past(status.current_floor)] ||
              lamps.panel_lamps[$past(status.current_floor)]))
        else begin
            other_count++;
            $display("lamp of the floor where the car stood was not cleared");
        end

    a_halt_no_lamp: assert property (@(posedge clock) disable iff (!reset_n)
        (buttons.emergency || !buttons.power) |=> ((lamps & ~$past(lamps)) == '0))
        else begin
            other_count++;
            $display("a lamp lit during emergency or power off");
        end

    a_halt_no_req: assert property (@(posedge clock) disable iff (!reset_n)
        (buttons.emergency || !buttons.power) |=> !$rose(move_req))
        else begin
            other_count++;
            $display("move_req rose during emergency or power off");
        end

    a_req: assert property (@(posedge clock) disable iff (!reset_n) move_req == exp_req)
        else begin
            mismatch_count++;
            $display("mismatch move_req: got %h expected %h", $sampled(move_req),
                     $sampled(exp_req));
        end

    a_cmd: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(move_req) |-> move_cmd == exp_cmd)
        else begin
            mismatch_count++;
            $display("mismatch move_cmd: got %h expected %h", $sampled(move_cmd),
                     $sampled(exp_cmd));
        end

    a_cmd_held: assert property (@(posedge clock) disable iff (!reset_n)
        (move_req && $past(move_req)) |-> $stable(move_cmd))
        else begin
            other_count++;
            $display("move_cmd changed while move_req was high");
        end

    a_fall_after_ack: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(move_req) |-> $past(move_ack))
        else begin
            other_count++;
            $display("move_req fell before move_ack was seen high");
        end

    a_door_open: assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == exp_door_open)
        else begin
            mismatch_count++;
            $display("mismatch door_open_allowed: got %h expected %h",
                     $sampled(door_open_allowed), $sampled(exp_door_open));
        end

    a_door_close: assert property (@(posedge clock) disable iff (!reset_n)
        door_close_allowed == exp_door_close)
        else begin
            mismatch_count++;
            $display("mismatch door_close_allowed: got %h expected %h",
                     $sampled(door_close_allowed), $sampled(exp_door_close));
        end

    ////////////////////
    // Motion controller model
    ////////////////////

    initial begin
        floor_t tgt;
        floor_t cur;
        @(posedge reset_n);
        forever begin
            @(posedge clock);
            if (move_req && !move_ack) begin
                tgt = move_cmd.target_floor;
                repeat ($urandom_range(0, 3)) @(posedge clock);
                move_ack <= 1'b1;
                @(posedge clock);
                while (move_req) @(posedge clock);
                repeat ($urandom_range(0, 3)) @(posedge clock);
                move_ack <= 1'b0;
                @(posedge clock);
                status.moving <= 1'b1;
                cur = status.current_floor;
                while (cur != tgt) begin
                    repeat (2) @(posedge clock);
                    cur = (tgt > cur) ? cur + 1'b1 : cur - 1'b1;
                    status.current_floor <= cur;
                    if (cur == tgt) status.moving <= 1'b0;
                end
                moves_done++;
            end
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= 4000) begin
            $display("run stopped by the cycle limit at %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        button_bank_t b;
        int           phase;
        void'($urandom(32'ha1bc_1a2e));
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        moves_done     = 0;
        reset_n        = 1'b0;
        buttons        = '0;
        buttons.power  = 1'b1;
        status         = '0;
        move_ack       = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        for (int c = 0; c < 3500; c++) begin
            @(posedge clock);
            b       = '0;
            b.power = 1'b1;
            if ($urandom_range(0, 5) == 0) b.hall_calls[$urandom_range(0, 10)] = 1'b1;
            if ($urandom_range(0, 7) == 0) b.panel_buttons[$urandom_range(0, 10)] = 1'b1;
            b.door_open  = ($urandom_range(0, 3) == 0);
            b.door_close = ($urandom_range(0, 3) == 0);
            // Emergency and power-off stretches every 400 cycles
            phase = c % 400;
            if (phase >= 300 && phase < 330) b.emergency = 1'b1;
            if (phase >= 340 && phase < 370) b.power = 1'b0;
            buttons <= b;
        end
        if (moves_done == 0) begin
            other_count++;
            $display("the car never made a move");
        end
        $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* elevator_ctrl.sv */
// Elevator request controller top joining call register, selector and command stage

`timescale 1ns/10ps

module elevator_ctrl (
    input  logic                      clock,
    input  logic                      reset_n,
    input  car_io_pkg::button_bank_t  buttons,
    input  car_io_pkg::car_status_t   status,
    input  logic                      move_ack,
    output car_io_pkg::lamp_bank_t    lamps,
    output car_io_pkg::move_cmd_t     move_cmd,
    output logic                      move_req,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import car_io_pkg::*;

    move_cmd_t target;
    logic      target_valid;
    logic      move_issued;

    // Button presses into lamps
    call_register call_register_i (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (buttons),
        .status  (status),
        .lamps   (lamps)
    );

    // Next floor from the lamps
    floor_select floor_select_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .lamps        (lamps),
        .status       (status),
        .move_issued  (move_issued),
        .target       (target),
        .target_valid (target_valid)
    );

    // Handshake with the motion controller
    car_command car_command_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .status             (status),
        .target             (target),
        .target_valid       (target_valid),
        .move_ack           (move_ack),
        .move_cmd           (move_cmd),
        .move_req           (move_req),
        .move_issued        (move_issued),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* car_command.sv */
// Move command issuer with a four-phase req/ack handshake and registered door permits

`timescale 1ns/10ps

module car_command (
    input  logic                      clock,
    input  logic                      reset_n,
    input  car_io_pkg::button_bank_t  buttons,
    input  car_io_pkg::car_status_t   status,
    input  car_io_pkg::move_cmd_t     target,
    input  logic                      target_valid,
    input  logic                      move_ack,
    output car_io_pkg::move_cmd_t     move_cmd,
    output logic                      move_req,
    output logic                      move_issued,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import car_io_pkg::*;
    import floor_pkg::*;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_REQ,
        CMD_RELEASE
    } cmd_state_t;

    cmd_state_t state;
    logic       car_ready;

    ////////////////////
    // Launch condition
    ////////////////////

    // Car parked, powered and not in emergency
    assign car_ready = !status.moving && buttons.power && !buttons.emergency;

    // Strobe for the edge that raises move_req
    assign move_issued = (state == CMD_IDLE) && target_valid && car_ready && !move_ack;

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= CMD_IDLE;
            move_req <= 1'b0;
        end else begin
            case (state)
                CMD_IDLE: begin
                    if (move_issued) begin
                        move_req <= 1'b1;
                        state    <= CMD_REQ;
                    end
                end
                CMD_REQ: begin
                    // Hold the request until the controller takes it
                    if (move_ack) begin
                        move_req <= 1'b0;
                        state    <= CMD_RELEASE;
                    end
                end
                CMD_RELEASE: begin
                    if (!move_ack) begin
                        state <= CMD_IDLE;
                    end
                end
                default: begin
                    move_req <= 1'b0;
                    state    <= CMD_IDLE;
                end
            endcase
        end
    end

    // Command payload is frozen for the whole request
    always_ff @(posedge clock) begin
        if (move_issued) begin
            move_cmd <= target;
        end
    end

    ////////////////////
    // Door permits
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= buttons.door_open && !status.moving && buttons.power;
            door_close_allowed <= buttons.door_close && !status.moving && buttons.power;
        end
    end

    a_cmd_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        move_req ##1 move_req |-> $stable(move_cmd)
    ) else $error("move_cmd changed while move_req was high");

    a_req_after_ack_low: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(move_req) |-> !$past(move_ack)
    ) else $error("move_req rose while move_ack was still high");

endmodule

/* floor_select.sv */
// Target selector picking the next floor and direction from the lit lamps

`timescale 1ns/10ps

`include "elevator_params.svh"

module floor_select (
    input  logic                     clock,
    input  logic                     reset_n,
    input  car_io_pkg::lamp_bank_t   lamps,
    input  car_io_pkg::car_status_t  status,
    input  logic                     move_issued,
    output car_io_pkg::move_cmd_t    target,
    output logic                     target_valid
);

    import car_io_pkg::*;
    import floor_pkg::*;

    floor_mask_t pending;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    floor_t      lowest_above;
    floor_t      highest_below;
    logic        any_above;
    logic        any_below;
    direction_t  last_dir;

    ////////////////////
    // Pending requests
    ////////////////////

    assign pending = lamps.call_lamps | lamps.panel_lamps;

    // Split the requests around the current floor
    always_comb begin
        above_mask = '0;
        below_mask = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (floor_t'(i) > status.current_floor) begin
                above_mask[i] = pending[i];
            end
            if (floor_t'(i) < status.current_floor) begin
                below_mask[i] = pending[i];
            end
        end
    end

    // Nearest request on each side
    always_comb begin
        lowest_above  = '0;
        highest_below = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (above_mask[i]) begin
                lowest_above = floor_t'(i);
            end
        end
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (below_mask[i]) begin
                highest_below = floor_t'(i);
            end
        end
    end

    assign any_above = |above_mask;
    assign any_below = |below_mask;

    ////////////////////
    // Selection
    ////////////////////

    // Keep going up while something is above, else prefer going down
    always_comb begin
        if (last_dir == DIR_UP && any_above) begin
            target.target_floor = lowest_above;
            target.dir          = DIR_UP;
        end else if (any_below) begin
            target.target_floor = highest_below;
            target.dir          = DIR_DOWN;
        end else begin
            target.target_floor = lowest_above;
            target.dir          = DIR_UP;
        end
    end

    assign target_valid = any_above | any_below;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            last_dir <= DIR_UP;
        end else if (move_issued) begin
            last_dir <= target.dir;
        end
    end

    // Motion controller must report a served floor
    a_floor_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        status.current_floor <= `TOP_FLOOR
    ) else $error("current floor %0d out of range", status.current_floor);

endmodule

/* call_register.sv */
// Call register that latches hall and panel presses into lamps and clears them on arrival

`timescale 1ns/10ps

`include "elevator_params.svh"

module call_register (
    input  logic                      clock,
    input  logic                      reset_n,
    input  car_io_pkg::button_bank_t  buttons,
    input  car_io_pkg::car_status_t   status,
    output car_io_pkg::lamp_bank_t    lamps
);

    import car_io_pkg::*;

    lamp_bank_t lamps_next;
    logic       floor_lit;

    ////////////////////
    // Lamp update
    ////////////////////

    always_comb begin
        lamps_next = lamps;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            // New presses only count with the car powered and no emergency
            if (buttons.power && !buttons.emergency &&
                status.current_floor != `FLOOR_W'(i)) begin
                if (buttons.hall_calls[i]) begin
                    lamps_next.call_lamps[i] = 1'b1;
                end
                if (buttons.panel_buttons[i]) begin
                    lamps_next.panel_lamps[i] = 1'b1;
                end
            end
            // Car standing here serves both requests
            if (buttons.power && !status.moving &&
                status.current_floor == `FLOOR_W'(i)) begin
                lamps_next.call_lamps[i]  = 1'b0;
                lamps_next.panel_lamps[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else begin
            lamps <= lamps_next;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Either lamp of the floor the car is at
    assign floor_lit = lamps.call_lamps[status.current_floor] |
                       lamps.panel_lamps[status.current_floor];

    // A stopped car never sees its own floor light up
    a_no_lamp_at_stop: assert property (
        @(posedge clock) disable iff (!reset_n)
        !status.moving ##1 (!status.moving && $stable(status.current_floor))
            |-> !$rose(floor_lit)
    ) else $error("lamp lit at floor %0d with the car stopped", status.current_floor);

endmodule

/* car_io_pkg.sv */
// Car I/O package with the button bank, car status, lamp bank and move command

package car_io_pkg;

    import floor_pkg::*;

    ////////////////////
    // Inputs
    ////////////////////

    // All buttons and switches of the car, active high
    typedef struct packed {
        floor_mask_t hall_calls;     // Call buttons at the landings
        floor_mask_t panel_buttons;  // Destination buttons in the car
        logic        door_open;
        logic        door_close;
        logic        emergency;
        logic        power;          // Main power switch
    } button_bank_t;

    // Status reported by the motion controller
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    ////////////////////
    // Outputs
    ////////////////////

    // Lamps behind the hall and panel buttons
    typedef struct packed {
        floor_mask_t call_lamps;
        floor_mask_t panel_lamps;
    } lamp_bank_t;

    // One move order for the motion controller
    typedef struct packed {
        floor_t     target_floor;
        direction_t dir;
    } move_cmd_t;

endpackage

/* floor_pkg.sv */
// Floor package with floor numbers, per-floor masks and travel direction

`include "elevator_params.svh"

package floor_pkg;

    ////////////////////
    // Floor types
    ////////////////////

    // Floor number, ground floor is zero
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per served floor, bit 0 is the ground floor
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    ////////////////////
    // Direction
    ////////////////////

    // Travel direction of the car
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

/* elevator_params.svh */
// Global sizing macros for the elevator request controller

`ifndef ELEVATOR_PARAMS_SVH
`define ELEVATOR_PARAMS_SVH

////////////////////
// Building size
////////////////////

// Number of served floors, counted from zero
`define NUM_FLOORS 11

// Bits needed for one floor number
`define FLOOR_W 4

// Highest legal floor number
`define TOP_FLOOR (`NUM_FLOORS - 1)

`endif
